//--- include/des_consts.svh
`ifndef DES_CONSTS_SVH
`define DES_CONSTS_SVH

// --------------------
// Cipher widths
// --------------------
`define DES_BLOCK_W      64
`define DES_HALF_W       32
`define DES_CD_W         28
`define DES_SUBKEY_W     48
`define DES_ROUNDS       16

// --------------------
// Panel and display
// --------------------
`define DES_CHUNK_W      16
`define DES_DIGITS       8
`define DES_SEG_W        7

// Depth of the button synchronizer chain
`define DES_SYNC_STAGES  2

// Standard known-answer vector loaded at reset
`define DES_RESET_DATA   64'h0123456789ABCDEF
`define DES_RESET_KEY    64'h133457799BBCDFF1

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the DES panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module des_panel_tb -f sim.f -o des_panel_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/des_panel_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- sim.f
+incdir+include
src/des_pkg.sv
src/des_panel_input.sv
src/des_key_schedule.sv
src/des_round_f.sv
src/des_round_engine.sv
src/des_seg_display.sv
src/des_panel_top.sv
tests/des_panel_assert.sv
tests/des_panel_tb.sv

//--- src/des_key_schedule.sv
`include "des_consts.svh"

module des_key_schedule (
    input  logic                clk,
    input  logic                load,
    input  des_pkg::des_op_e    op,
    input  des_pkg::block_t     key,
    input  logic                advance,
    input  des_pkg::round_idx_t round,
    output des_pkg::subkey_t    subkey
);

    localparam int PC1_TBL [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TBL [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
        26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    logic [2*`DES_CD_W-1:0] pc1_out;
    logic [2*`DES_CD_W-1:0] cd_next;
    des_pkg::cd_half_t      c_q;
    des_pkg::cd_half_t      d_q;
    logic [1:0]             amount;
    logic                   rot_right;

    // Rotate one key half by 0, 1 or 2 places
    function automatic des_pkg::cd_half_t rotate(input des_pkg::cd_half_t x,
                                                 input logic [1:0]        amt,
                                                 input logic              right);
        des_pkg::cd_half_t y;
        case (amt)
            2'd0:    y = x;
            2'd1:    y = right ? {x[0], x[`DES_CD_W-1:1]} : {x[`DES_CD_W-2:0], x[`DES_CD_W-1]};
            default: y = right ? {x[1:0], x[`DES_CD_W-1:2]}
                               : {x[`DES_CD_W-3:0], x[`DES_CD_W-1:`DES_CD_W-2]};
        endcase
        return y;
    endfunction

    always_comb begin
        for (int i = 0; i < 56; i++) begin
            pc1_out[55-i] = key[`DES_BLOCK_W-PC1_TBL[i]];
        end
    end

    // Decryption walks the schedule backwards, starting from C0/D0 unrotated
    always_comb begin
        rot_right = (op == des_pkg::OP_DECRYPT);
        if (rot_right && round == '0) begin
            amount = 2'd0;
        end else if (round inside {4'd1, 4'd8, 4'd15} || (!rot_right && round == '0)) begin
            amount = 2'd1;
        end else begin
            amount = 2'd2;
        end
    end

    assign cd_next = {rotate(c_q, amount, rot_right), rotate(d_q, amount, rot_right)};

    // Subkey comes straight from the rotated value
    always_comb begin
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            subkey[`DES_SUBKEY_W-1-i] = cd_next[2*`DES_CD_W-PC2_TBL[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            {c_q, d_q} <= pc1_out;
        end else if (advance) begin
            {c_q, d_q} <= cd_next;
        end
    end

endmodule

//--- src/des_panel_input.sv
`include "des_consts.svh"

module des_panel_input (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [3:1]        key_n,
    input  logic [17:0]       sw,
    input  logic [1:0]        chunk_sel,
    input  logic              ready,
    output des_pkg::des_req_t req,
    output logic              start
);

    // key_n[1] encrypt, key_n[2] decrypt, key_n[3] load chunk
    logic [`DES_SYNC_STAGES:0][3:1] sync_q;
    logic [3:1]                     level;
    logic [3:1]                     level_prev;
    logic [3:1]                     fall;

    des_pkg::block_t  data_q;
    des_pkg::block_t  key_q;
    des_pkg::des_op_e op_q;

    // --------------------
    // Button synchronizers
    // --------------------

    // Buttons idle high, so the chain resets to ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[`DES_SYNC_STAGES-1:0], key_n};
        end
    end

    // Last stage keeps the previous level for edge detection
    assign level      = sync_q[`DES_SYNC_STAGES-1];
    assign level_prev = sync_q[`DES_SYNC_STAGES];
    assign fall       = level_prev & ~level;

    // --------------------
    // Chunk loading
    // --------------------

    // sw[17] picks data or key, chunk_sel the 16-bit position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_q <= `DES_RESET_DATA;
            key_q  <= `DES_RESET_KEY;
        end else if (fall[3]) begin
            if (sw[17]) begin
                key_q[chunk_sel*`DES_CHUNK_W +: `DES_CHUNK_W] <= sw[`DES_CHUNK_W-1:0];
            end else begin
                data_q[chunk_sel*`DES_CHUNK_W +: `DES_CHUNK_W] <= sw[`DES_CHUNK_W-1:0];
            end
        end
    end

    // --------------------
    // Start requests
    // --------------------

    // Presses while busy are dropped; encrypt wins a tie
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            op_q  <= des_pkg::OP_ENCRYPT;
        end else begin
            start <= (fall[1] | fall[2]) & ready;
            if ((fall[1] | fall[2]) && ready) begin
                op_q <= fall[1] ? des_pkg::OP_ENCRYPT : des_pkg::OP_DECRYPT;
            end
        end
    end

    assign req = '{op: op_q, data: data_q, key: key_q};

endmodule

//--- src/des_panel_top.sv
module des_panel_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [3:1]           key_n,
    input  logic [17:0]          sw,
    input  logic [1:0]           chunk_sel,
    output des_pkg::seg_digits_t hex,
    output logic                 ready
);

    des_pkg::des_req_t req;
    des_pkg::block_t   result;
    logic              start;

    // --------------------
    // Switches and buttons
    // --------------------
    des_panel_input u_panel_input (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_n     (key_n),
        .sw        (sw),
        .chunk_sel (chunk_sel),
        .ready     (ready),
        .req       (req),
        .start     (start)
    );

    // --------------------
    // Cipher
    // --------------------
    des_round_engine u_round_engine (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .req    (req),
        .result (result),
        .ready  (ready)
    );

    // Only the low word fits on the eight digits
    des_seg_display u_seg_display (
        .value (result[31:0]),
        .hex   (hex)
    );

endmodule

//--- src/des_pkg.sv
`include "des_consts.svh"

package des_pkg;

    // --------------------
    // Data widths
    // --------------------

    // Full plaintext or ciphertext block
    typedef logic [`DES_BLOCK_W-1:0] block_t;

    // One Feistel half
    typedef logic [`DES_HALF_W-1:0] half_t;

    // C or D key half after PC1
    typedef logic [`DES_CD_W-1:0] cd_half_t;

    // Key for one round, after PC2
    typedef logic [`DES_SUBKEY_W-1:0] subkey_t;

    // Counts rounds 0 to 15
    typedef logic [$clog2(`DES_ROUNDS)-1:0] round_idx_t;

    // --------------------
    // Encodings
    // --------------------

    typedef enum logic {
        OP_ENCRYPT,
        OP_DECRYPT
    } des_op_e;

    typedef enum logic {
        ST_IDLE,
        ST_ROUNDS
    } engine_state_e;

    // Request from the panel to the engine, copied at start
    typedef struct packed {
        des_op_e op;
        block_t  data;
        block_t  key;
    } des_req_t;

    // Active-low segments, digit 0 holds the lowest nibble
    typedef logic [`DES_DIGITS-1:0][`DES_SEG_W-1:0] seg_digits_t;

endpackage

//--- src/des_round_engine.sv
`include "des_consts.svh"

module des_round_engine (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  des_pkg::des_req_t req,
    output des_pkg::block_t   result,
    output logic              ready
);

    localparam int IP_TBL [64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    localparam int FP_TBL [64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    des_pkg::engine_state_e state;
    des_pkg::round_idx_t    round_q;
    des_pkg::des_op_e       op_q;
    des_pkg::half_t         l_q;
    des_pkg::half_t         r_q;
    des_pkg::half_t         f_out;
    des_pkg::subkey_t       subkey;
    des_pkg::block_t        ip_out;
    des_pkg::block_t        fp_out;
    logic                   accept;
    logic                   in_rounds;
    logic                   last_round;

    // Table numbering is 1-based from the MSB
    function automatic des_pkg::block_t permute64(input des_pkg::block_t x,
                                                  input int             tbl [64]);
        des_pkg::block_t y;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            y[`DES_BLOCK_W-1-i] = x[`DES_BLOCK_W-tbl[i]];
        end
        return y;
    endfunction

    assign accept     = start && (state == des_pkg::ST_IDLE);
    assign in_rounds  = (state == des_pkg::ST_ROUNDS);
    assign last_round = (round_q == des_pkg::round_idx_t'(`DES_ROUNDS - 1));
    assign ready      = (state == des_pkg::ST_IDLE);

    assign ip_out = permute64(req.data, IP_TBL);

    // Halves swap back before FP
    assign fp_out = permute64({l_q ^ f_out, r_q}, FP_TBL);

    // --------------------
    // Round controller
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= des_pkg::ST_IDLE;
            round_q <= '0;
            op_q    <= des_pkg::OP_ENCRYPT;
            result  <= '0;
        end else begin
            case (state)
                des_pkg::ST_IDLE: begin
                    if (start) begin
                        state   <= des_pkg::ST_ROUNDS;
                        round_q <= '0;
                        op_q    <= req.op;
                    end
                end
                default: begin
                    round_q <= des_pkg::round_idx_t'(round_q + 1'b1);
                    if (last_round) begin
                        state  <= des_pkg::ST_IDLE;
                        result <= fp_out;
                    end
                end
            endcase
        end
    end

    // --------------------
    // Feistel datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            l_q <= ip_out[`DES_BLOCK_W-1:`DES_HALF_W];
            r_q <= ip_out[`DES_HALF_W-1:0];
        end else if (in_rounds) begin
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
    end

    des_key_schedule u_key_schedule (
        .clk     (clk),
        .load    (accept),
        .op      (op_q),
        .key     (req.key),
        .advance (in_rounds),
        .round   (round_q),
        .subkey  (subkey)
    );

    des_round_f u_round_f (
        .r_half (r_q),
        .subkey (subkey),
        .f_out  (f_out)
    );

endmodule

//--- src/des_round_f.sv
`include "des_consts.svh"

module des_round_f (
    input  des_pkg::half_t   r_half,
    input  des_pkg::subkey_t subkey,
    output des_pkg::half_t   f_out
);

    localparam int E_TBL [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    localparam int P_TBL [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    // Row-major, 16 entries per row, four rows per box
    localparam int SBOX [8][64] = '{
        '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
           0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
           4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
          15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
        '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
           3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
           0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
          13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
        '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
          13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
          13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
           1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
        '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
          13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
          10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
           3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
        '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
          14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
           4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
          11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
        '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
          10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
           9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
           4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
        '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
          13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
           1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
           6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
        '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
           1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
           7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
           2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
    };

    des_pkg::subkey_t mixed;
    des_pkg::half_t   s_out;
    logic [5:0]       six;

    // E expansion then subkey mix
    always_comb begin
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            mixed[`DES_SUBKEY_W-1-i] = r_half[`DES_HALF_W-E_TBL[i]] ^ subkey[`DES_SUBKEY_W-1-i];
        end
    end

    // Outer bits pick the row, inner four the column
    always_comb begin
        six = '0;
        for (int b = 0; b < 8; b++) begin
            six = mixed[`DES_SUBKEY_W-1-6*b -: 6];
            s_out[`DES_HALF_W-1-4*b -: 4] = 4'(SBOX[b][{six[5], six[0], six[4:1]}]);
        end
    end

    always_comb begin
        for (int i = 0; i < `DES_HALF_W; i++) begin
            f_out[`DES_HALF_W-1-i] = s_out[`DES_HALF_W-P_TBL[i]];
        end
    end

endmodule

//--- src/des_seg_display.sv
`include "des_consts.svh"

module des_seg_display (
    input  des_pkg::half_t      value,
    output des_pkg::seg_digits_t hex
);

    // Segment order gfedcba, a lit segment is 0
    function automatic logic [`DES_SEG_W-1:0] glyph(input logic [3:0] nib);
        logic [`DES_SEG_W-1:0] seg;
        case (nib)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;
            4'hE:    seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    always_comb begin
        for (int d = 0; d < `DES_DIGITS; d++) begin
            hex[d] = glyph(value[4*d +: 4]);
        end
    end

endmodule

//--- tests/des_panel_assert.sv
`include "des_consts.svh"

module des_panel_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic [3:1]           key_n,
    input logic                 ready,
    input logic                 start,
    input des_pkg::seg_digits_t hex
);

    timeunit 1ns;
    timeprecision 1ps;

    // Active-low digit glyphs 0 to F in segment order gfedcba
    localparam logic [6:0] GLYPHS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    int                   fail_count = 0;
    int                   since_start;
    int                   press_age;
    logic                 saw_busy;
    logic [2:1]           key_prev;
    logic                 check_en;
    des_pkg::half_t       expected_low;
    des_pkg::seg_digits_t expected_hex;

    assign check_en     = des_panel_tb.check_en;
    assign expected_low = des_panel_tb.expected_low;

    always_comb begin
        for (int d = 0; d < `DES_DIGITS; d++) begin
            expected_hex[d] = GLYPHS[expected_low[4*d +: 4]];
        end
    end

    // --------------------
    // Timing trackers
    // --------------------

    // Cycles since the engine saw start
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_start <= 0;
        end else if (start) begin
            since_start <= 1;
        end else if (since_start != 0) begin
            since_start <= (since_start == 17) ? 0 : since_start + 1;
        end
    end

    // Age of a start press made while idle
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_prev  <= 2'b11;
            press_age <= 0;
            saw_busy  <= 1'b0;
        end else begin
            key_prev <= key_n[2:1];
            if (press_age == 0) begin
                if (|(key_prev & ~key_n[2:1]) && ready) begin
                    press_age <= 1;
                    saw_busy  <= 1'b0;
                end
            end else if (press_age >= 23 || (ready && saw_busy)) begin
                press_age <= 0;
            end else begin
                press_age <= press_age + 1;
                if (!ready) begin
                    saw_busy <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // Checks
    // --------------------

    a_display: assert property (@(negedge clk) disable iff (!rst_n)
        check_en |-> hex == expected_hex)
        else begin
            fail_count++;
            $error("mismatch hex: expected %h got %h", expected_hex, hex);
        end

    a_idle_ready: assert property (@(negedge clk) disable iff (!rst_n)
        check_en |-> ready)
        else begin
            fail_count++;
            $error("mismatch ready: expected %h got %h", 1'b1, ready);
        end

    a_rounds_busy: assert property (@(negedge clk) disable iff (!rst_n)
        (since_start >= 1 && since_start <= 16) |-> !ready)
        else begin
            fail_count++;
            $error("mismatch ready in round %0d: expected %h got %h",
                   since_start - 1, 1'b0, ready);
        end

    a_rounds_done: assert property (@(negedge clk) disable iff (!rst_n)
        since_start == 17 |-> ready)
        else begin
            fail_count++;
            $error("mismatch ready after 16 rounds: expected %h got %h", 1'b1, ready);
        end

    a_press_falls: assert property (@(negedge clk) disable iff (!rst_n)
        press_age == 6 |-> saw_busy)
        else begin
            fail_count++;
            $error("mismatch ready within 5 cycles of press: expected %h got %h", 1'b0, ready);
        end

    a_press_rises: assert property (@(negedge clk) disable iff (!rst_n)
        press_age <= 22)
        else begin
            fail_count++;
            $error("mismatch ready within 22 cycles of press: expected %h got %h", 1'b1, ready);
        end

endmodule

//--- tests/des_panel_tb.sv
`include "des_consts.svh"

module des_panel_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 10;
    localparam int PRESS_CYCLES    = 4;
    localparam int READY_LIMIT     = 40;
    // Start presses, busy presses and chunk loads
    localparam int NUM_OPS         = 26;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 40 + RESET_CYCLES;

    logic                 clk;
    logic                 rst_n;
    logic [3:1]           key_n;
    logic [17:0]          sw;
    logic [1:0]           chunk_sel;
    des_pkg::seg_digits_t hex;
    logic                 ready;

    // Read by the bound checker
    des_pkg::half_t       expected_low;
    logic                 check_en;

    logic [7:0]           lfsr_q;
    int                   timeout_errors;
    int                   assert_errors;

    des_panel_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_n     (key_n),
        .sw        (sw),
        .chunk_sel (chunk_sel),
        .hex       (hex),
        .ready     (ready)
    );

    bind des_panel_top des_panel_assert u_assert (
        .clk   (clk),
        .rst_n (rst_n),
        .key_n (key_n),
        .ready (ready),
        .start (start),
        .hex   (hex)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------

    // Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // 0 to 7 idle cycles, one LFSR step per bit
    task automatic idle_gap();
        logic [2:0] gap;
        gap = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            gap    = {gap[1:0], lfsr_q[0]};
        end
        repeat (gap) step();
    endtask

    task automatic press_button(input int idx);
        key_n[idx] = 1'b0;
        repeat (PRESS_CYCLES) step();
        key_n[idx] = 1'b1;
        step();
    endtask

    task automatic load_chunk(input logic to_key, input logic [1:0] sel,
                              input logic [15:0] value);
        sw        = {to_key, 1'b0, value};
        chunk_sel = sel;
        press_button(3);
        idle_gap();
    endtask

    // Chunk 0 is the least significant 16 bits
    task automatic load_block(input logic to_key, input des_pkg::block_t value);
        for (int c = 0; c < 4; c++) begin
            load_chunk(to_key, 2'(c), value[`DES_CHUNK_W*c +: `DES_CHUNK_W]);
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!ready && waited < READY_LIMIT) begin
            step();
            waited++;
        end
        if (!ready) begin
            timeout_errors++;
            $display("ready did not return within %0d cycles", READY_LIMIT);
        end
    endtask

    task automatic publish(input des_pkg::half_t value);
        expected_low = value;
        check_en     = 1'b1;
        repeat (2) step();
        idle_gap();
    endtask

    task automatic run_op(input int button, input des_pkg::half_t value);
        check_en = 1'b0;
        press_button(button);
        wait_ready();
        publish(value);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        rst_n          = 1'b0;
        key_n          = '1;
        sw             = '0;
        chunk_sel      = '0;
        expected_low   = '0;
        check_en       = 1'b0;
        lfsr_q         = 8'd91;
        timeout_errors = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Idle after reset, blank result
        publish(32'h0000_0000);

        // Known answer with the reset vector
        run_op(1, 32'h0F0A_B405);

        // Round trip back to the plaintext
        load_block(1'b0, 64'h85E8_1354_0F0A_B405);
        run_op(2, 32'h89AB_CDEF);

        load_block(1'b1, 64'h0E32_9232_EA6D_0D73);
        load_block(1'b0, 64'h8787_8787_8787_8787);
        run_op(1, 32'h0000_0000);

        // Presses during the rounds must be dropped
        load_block(1'b1, `DES_RESET_KEY);
        load_block(1'b0, 64'h85E8_1354_0F0A_B405);
        check_en = 1'b0;
        press_button(2);
        press_button(1);
        press_button(2);
        wait_ready();
        publish(32'h89AB_CDEF);

        assert_errors = uut.u_assert.fail_count;
        $display("errors: %0d assertion failures, %0d timeouts",
                 assert_errors, timeout_errors);
        if (assert_errors == 0 && timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the number of operations
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule
